// File: list.f
+incdir+design
design/ecc_code_pkg.sv
design/ecc_status_pkg.sv
design/eccEncoder.sv
design/eccCorrector.sv
design/eccReg.sv
design/eccRegCfg.sv
design/eccRegTop.sv
testbench/eccRegTb_properties.sv
testbench/eccRegTb.sv

// File: Makefile
SRCS := list.f $(wildcard design/*.sv design/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/VeccRegTb: $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module eccRegTb -f list.f

# an aborted run prints neither message, so the pass message is required too
run: obj_dir/VeccRegTb
	./obj_dir/VeccRegTb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Test FAILED" sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/eccRegTb.sv
// ##################################################
// testbench of the ECC protected register
// loads LCG words, injects faults over the config
// bus and checks data and counters against a model
// ##################################################

`timescale 1ns/1ps

`include "ecc_settings.svh"

module eccRegTb;

  import ecc_code_pkg::*;
  import ecc_status_pkg::*;

  // longest wait for a flag, in clock cycles
  localparam int waitLimit = 10;

  logic    clk_i;
  logic    rstN_i;
  logic    loadEn_i;
  dataT    data_i;
  dataT    data_o;
  logic    errCorrectable_o;
  logic    errUncorrectable_o;
  logic    cfgWrEn_i;
  cfgAddrT cfgAddr_i;
  cfgDataT cfgWrData_i;
  cfgDataT cfgRdData_o;

  // reference model of the last loaded word and both counters
  dataT                   refData;
  int                     refCorrCount;
  int                     refUncorrCount;
  logic [`DATA_WIDTH-1:0] lcgState;
  int                     errorCount;
  int                     testCount;
  int                     failedTests;
  int                     errorsAtStart;

  eccRegTop i_eccRegTop (
    .clk_i              (clk_i             ),
    .rstN_i             (rstN_i            ),
    .loadEn_i           (loadEn_i          ),
    .data_i             (data_i            ),
    .data_o             (data_o            ),
    .errCorrectable_o   (errCorrectable_o  ),
    .errUncorrectable_o (errUncorrectable_o),
    .cfgWrEn_i          (cfgWrEn_i         ),
    .cfgAddr_i          (cfgAddr_i         ),
    .cfgWrData_i        (cfgWrData_i       ),
    .cfgRdData_o        (cfgRdData_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // plain 32-bit LCG, the low bits repeat quickly so positions use bits 20 to 16
  function automatic dataT nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  function automatic int randPos();
    dataT r;
    r = nextRand();
    return int'(r[20:16]);
  endfunction

  // inputs change 5 ns after the rising edge
  task automatic stepClock();
    @(posedge clk_i);
    #5;
  endtask

  task automatic abortRun(input string what);
    $display("timeout while waiting for %s", what);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic loadWord(input dataT word);
    loadEn_i = 1'b1;
    data_i   = word;
    stepClock();
    loadEn_i = 1'b0;
    refData  = word;
  endtask

  task automatic writeCfg(input cfgAddrT addr, input cfgDataT value);
    cfgWrEn_i   = 1'b1;
    cfgAddr_i   = addr;
    cfgWrData_i = value;
    stepClock();
    cfgWrEn_i   = 1'b0;
  endtask

  task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkFlags(input logic corr, input logic uncorr);
    checkValue("errCorrectable_o", 32'(errCorrectable_o), 32'(corr));
    checkValue("errUncorrectable_o", 32'(errUncorrectable_o), 32'(uncorr));
  endtask

  // the read path is combinational, so the value settles within the cycle
  task automatic checkCfg(input cfgAddrT addr, input int exp);
    cfgAddr_i = addr;
    #10;
    checkValue(addr.name(), cfgRdData_o, exp);
  endtask

  task automatic waitFlag(input logic uncorr, input string what);
    int cycles;
    cycles = 0;
    while ((uncorr ? errUncorrectable_o : errCorrectable_o) !== 1'b1) begin
      if (cycles == waitLimit) begin
        abortRun(what);
      end else begin
        stepClock();
        cycles++;
      end
    end
  endtask

  task automatic startTest();
    errorsAtStart = errorCount;
    testCount++;
  endtask

  task automatic endTest(input string name);
    if (errorCount == errorsAtStart) begin
      $display("test %0d %s: passed", testCount, name);
    end else begin
      failedTests++;
      $display("test %0d %s: failed", testCount, name);
    end
  endtask

  initial begin
    int highCycles;
    int posA;
    int posB;
    rstN_i         = 1'b1;
    loadEn_i       = 1'b0;
    data_i         = '0;
    cfgWrEn_i      = 1'b0;
    cfgAddr_i      = CTRL;
    cfgWrData_i    = '0;
    lcgState       = 11;
    refData        = '0;
    refCorrCount   = 0;
    refUncorrCount = 0;
    errorCount     = 0;
    testCount      = 0;
    failedTests    = 0;
    // a real falling edge, so the asynchronous reset acts before the first clock edge
    #1 rstN_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #5 rstN_i = 1'b1;

    startTest();
    checkValue("data_o", data_o, refData);
    checkFlags(1'b0, 1'b0);
    checkCfg(CTRL, 1);
    checkCfg(CORR_COUNT, 0);
    checkCfg(UNCORR_COUNT, 0);
    endTest("reset state");

    startTest();
    for (int i = 0; i < 20; i++) begin
      loadWord(nextRand());
      checkValue("data_o", data_o, refData);
      checkFlags(1'b0, 1'b0);
    end
    endTest("load and read back");

    // the fault lands one edge after the INJECT write and is scrubbed one edge later
    startTest();
    loadWord(nextRand());
    writeCfg(INJECT, cfgDataT'(1) << randPos());
    // the mask register is write only
    checkCfg(INJECT, 0);
    waitFlag(1'b0, "the correctable flag after a single-bit injection");
    highCycles = 0;
    while (errCorrectable_o && highCycles < waitLimit) begin
      checkValue("data_o", data_o, refData);
      highCycles++;
      stepClock();
    end
    checkValue("cycles with errCorrectable_o high", highCycles, 1);
    refCorrCount++;
    checkCfg(CORR_COUNT, refCorrCount);
    checkValue("data_o", data_o, refData);
    endTest("single fault scrubbed");

    startTest();
    writeCfg(CTRL, 0);
    checkCfg(CTRL, 0);
    loadWord(nextRand());
    writeCfg(INJECT, cfgDataT'(1) << randPos());
    waitFlag(1'b0, "the correctable flag with self-correct off");
    // without scrubbing the fault stays, the output path still repairs it
    repeat (3) begin
      checkValue("data_o", data_o, refData);
      checkFlags(1'b1, 1'b0);
      stepClock();
    end
    checkCfg(CORR_COUNT, refCorrCount);
    loadWord(nextRand());
    checkValue("data_o", data_o, refData);
    checkFlags(1'b0, 1'b0);
    writeCfg(CTRL, 1);
    endTest("single fault held");

    startTest();
    loadWord(nextRand());
    posA = randPos();
    posB = (posA + 1 + randPos() % 31) % 32;
    writeCfg(INJECT, (cfgDataT'(1) << posA) | (cfgDataT'(1) << posB));
    waitFlag(1'b1, "the uncorrectable flag after a two-bit injection");
    // the counter sees the rising flag at the next edge
    stepClock();
    checkFlags(1'b0, 1'b1);
    refUncorrCount++;
    checkCfg(UNCORR_COUNT, refUncorrCount);
    loadWord(nextRand());
    checkValue("data_o", data_o, refData);
    checkFlags(1'b0, 1'b0);
    writeCfg(UNCORR_COUNT, 0);
    refUncorrCount = 0;
    checkCfg(UNCORR_COUNT, refUncorrCount);
    writeCfg(CORR_COUNT, 0);
    refCorrCount = 0;
    checkCfg(CORR_COUNT, refCorrCount);
    endTest("double fault and counter clear");

    startTest();
    loadWord(nextRand());
    writeCfg(INJECT, cfgDataT'(1) << randPos());
    waitFlag(1'b0, "the correctable flag before a competing load");
    // a scrub is pending in this cycle, the load takes the edge instead
    loadWord(nextRand());
    checkValue("data_o", data_o, refData);
    checkFlags(1'b0, 1'b0);
    checkCfg(CORR_COUNT, refCorrCount);
    endTest("load over pending scrub");

    $display("tests run: %0d, tests failed: %0d, errors: %0d", testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/eccRegTb_properties.sv
// ##################################################
// concurrent checks on the ECC register top
// bound into eccRegTop so the internal pulses show
// ##################################################

`timescale 1ns/1ps

module eccRegTbProperties (
  input logic clk_i,
  input logic rstN_i,
  input logic loadEn_i,
  input logic injectEn_i,
  input logic scrubDone_i,
  input logic errCorrectable_i,
  input logic errUncorrectable_i
);

  // a word is either repairable or not, never both
  flagsExclusive: assert property (
    @(posedge clk_i) disable iff (!rstN_i)
    !(errCorrectable_i && errUncorrectable_i)
  ) else $error("both error flags are high in the same cycle");

  // the scrub writes the repaired word, so the flag is gone one cycle later
  scrubClearsFlag: assert property (
    @(posedge clk_i) disable iff (!rstN_i)
    (scrubDone_i && !loadEn_i && !injectEn_i) |=> !errCorrectable_i
  ) else $error("errCorrectable_o still high one cycle after a scrub");

  // reset leaves the valid all-zero codeword in storage
  quietInReset: assert property (
    @(posedge clk_i)
    !rstN_i |-> (!errCorrectable_i && !errUncorrectable_i)
  ) else $error("an error flag is high during reset");

endmodule

bind eccRegTop eccRegTbProperties i_eccRegTbProperties (
  .clk_i              (clk_i             ),
  .rstN_i             (rstN_i            ),
  .loadEn_i           (loadEn_i          ),
  .injectEn_i         (injectEn          ),
  .scrubDone_i        (scrubDone         ),
  .errCorrectable_i   (errCorrectable_o  ),
  .errUncorrectable_i (errUncorrectable_o)
);

// File: design/eccRegTop.sv
// ##################################################
// top of the ECC protected register
// data port plus a small configuration bus
// ##################################################

`timescale 1ns/1ps

`include "ecc_settings.svh"

module eccRegTop (
  input  logic                    clk_i,
  input  logic                    rstN_i,
  input  logic                    loadEn_i,
  input  ecc_code_pkg::dataT      data_i,
  output ecc_code_pkg::dataT      data_o,
  output logic                    errCorrectable_o,
  output logic                    errUncorrectable_o,
  input  logic                    cfgWrEn_i,
  input  ecc_status_pkg::cfgAddrT cfgAddr_i,
  input  ecc_status_pkg::cfgDataT cfgWrData_i,
  output ecc_status_pkg::cfgDataT cfgRdData_o
);

  import ecc_code_pkg::*;

  codeT encoded;
  codeT stored;
  codeT corrected;
  logic errCorrectable;
  logic errUncorrectable;
  logic selfCorrectEn;
  logic injectEn;
  codeT injectMask;
  logic scrubDone;

  eccEncoder i_eccEncoder (
    .data_i (data_i ),
    .code_o (encoded)
  );

  eccReg i_eccReg (
    .clk_i            (clk_i         ),
    .rstN_i           (rstN_i        ),
    .loadEn_i         (loadEn_i      ),
    .encoded_i        (encoded       ),
    .corrected_i      (corrected     ),
    .errCorrectable_i (errCorrectable),
    .selfCorrectEn_i  (selfCorrectEn ),
    .injectEn_i       (injectEn      ),
    .injectMask_i     (injectMask    ),
    .stored_o         (stored        ),
    .scrubDone_o      (scrubDone     )
  );

  // decode sits after the register, so a load shows up right after its edge
  eccCorrector i_eccCorrector (
    .code_i             (stored          ),
    .code_o             (corrected       ),
    .errCorrectable_o   (errCorrectable  ),
    .errUncorrectable_o (errUncorrectable)
  );

  eccRegCfg i_eccRegCfg (
    .clk_i              (clk_i           ),
    .rstN_i             (rstN_i          ),
    .wrEn_i             (cfgWrEn_i       ),
    .addr_i             (cfgAddr_i       ),
    .wrData_i           (cfgWrData_i     ),
    .rdData_o           (cfgRdData_o     ),
    .scrubDone_i        (scrubDone       ),
    .errUncorrectable_i (errUncorrectable),
    .selfCorrectEn_o    (selfCorrectEn   ),
    .injectEn_o         (injectEn        ),
    .injectMask_o       (injectMask      )
  );

  // the output always carries repaired data, even while self-correct is off
  assign data_o             = extractData(corrected);
  assign errCorrectable_o   = errCorrectable;
  assign errUncorrectable_o = errUncorrectable;

endmodule

// File: design/eccRegCfg.sv
// ##################################################
// configuration and status block of the ECC register
// holds the enable, the fault mask and event counters
// ##################################################

`timescale 1ns/1ps

`include "ecc_settings.svh"

module eccRegCfg (
  input  logic                    clk_i,
  input  logic                    rstN_i,
  input  logic                    wrEn_i,
  input  ecc_status_pkg::cfgAddrT addr_i,
  input  ecc_status_pkg::cfgDataT wrData_i,
  output ecc_status_pkg::cfgDataT rdData_o,
  input  logic                    scrubDone_i,
  input  logic                    errUncorrectable_i,
  output logic                    selfCorrectEn_o,
  output logic                    injectEn_o,
  output ecc_code_pkg::codeT      injectMask_o
);

  import ecc_code_pkg::*;
  import ecc_status_pkg::*;

  logic  selfCorrectEnQ;
  logic  injectEnQ;
  codeT  injectMaskQ;
  countT corrCountQ;
  countT uncorrCountQ;
  // previous value of the uncorrectable flag for edge detection
  logic  uncorrPrevQ;
  logic  uncorrRise;

  assign uncorrRise = errUncorrectable_i && !uncorrPrevQ;

  // control bit, injection pulse and the flag history
  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      selfCorrectEnQ <= 1'b1;
      injectEnQ      <= 1'b0;
      uncorrPrevQ    <= 1'b0;
    end else begin
      if (wrEn_i && addr_i == CTRL) begin
        selfCorrectEnQ <= wrData_i[0];
      end
      // one cycle after the write, so the mask is already in place
      injectEnQ   <= wrEn_i && addr_i == INJECT;
      uncorrPrevQ <= errUncorrectable_i;
    end
  end

  // the mask is only looked at while the pulse is high
  // the bus is 32 bits wide so the upper codeword bits are never masked
  always_ff @(posedge clk_i) begin
    if (wrEn_i && addr_i == INJECT) begin
      injectMaskQ <= CODE_WIDTH'(wrData_i);
    end
  end

  // saturating counters, a write to a counter address clears it
  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      corrCountQ   <= '0;
      uncorrCountQ <= '0;
    end else begin
      if (wrEn_i && addr_i == CORR_COUNT) begin
        corrCountQ <= '0;
      end else if (scrubDone_i && corrCountQ != COUNT_MAX) begin
        corrCountQ <= corrCountQ + 1'b1;
      end
      // a held flag counts once, only its rising edge is seen
      if (wrEn_i && addr_i == UNCORR_COUNT) begin
        uncorrCountQ <= '0;
      end else if (uncorrRise && uncorrCountQ != COUNT_MAX) begin
        uncorrCountQ <= uncorrCountQ + 1'b1;
      end
    end
  end

  // reads are combinational from the address
  always_comb begin
    case (addr_i)
      CTRL:         rdData_o = cfgDataT'(selfCorrectEnQ);
      CORR_COUNT:   rdData_o = cfgDataT'(corrCountQ);
      UNCORR_COUNT: rdData_o = cfgDataT'(uncorrCountQ);
      default:      rdData_o = '0;
    endcase
  end

  assign selfCorrectEn_o = selfCorrectEnQ;
  assign injectEn_o      = injectEnQ;
  assign injectMask_o    = injectMaskQ;

endmodule

// File: design/eccReg.sv
// ##################################################
// storage for one SECDED codeword
// loads, takes injected faults and scrubs itself
// ##################################################

`timescale 1ns/1ps

`include "ecc_settings.svh"

module eccReg (
  input  logic               clk_i,
  input  logic               rstN_i,
  input  logic               loadEn_i,
  input  ecc_code_pkg::codeT encoded_i,
  input  ecc_code_pkg::codeT corrected_i,
  input  logic               errCorrectable_i,
  input  logic               selfCorrectEn_i,
  input  logic               injectEn_i,
  input  ecc_code_pkg::codeT injectMask_i,
  output ecc_code_pkg::codeT stored_o,
  output logic               scrubDone_o
);

  import ecc_code_pkg::*;

  codeT storedQ;
  // a scrub is committed at the coming edge
  logic scrubNow;

  // a load or an injection in the same cycle takes precedence over the scrub
  assign scrubNow = errCorrectable_i && selfCorrectEn_i && !loadEn_i && !injectEn_i;

  // the codeword register, next value chosen by priority
  // load first, then fault injection, then scrub, else hold
  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      // all zero is a valid codeword of the all-zero data word
      storedQ <= '0;
    end else if (loadEn_i) begin
      storedQ <= encoded_i;
    end else if (injectEn_i) begin
      // flips the masked bits of whatever is stored right now
      storedQ <= storedQ ^ injectMask_i;
    end else if (scrubNow) begin
      storedQ <= corrected_i;
    end
  end

  assign stored_o = storedQ;

  // the pulse is high during the cycle whose closing edge writes the fix
  // the corrector then sees a clean word and drops its flag
  assign scrubDone_o = scrubNow;

  // with self-correct off the faulty word stays put until the next load
  // and the corrector keeps repairing it on the output path

endmodule

// File: design/eccCorrector.sv
// ##################################################
// combinational SECDED check and correction
// returns the fixed codeword and the error class
// ##################################################

`timescale 1ns/1ps

`include "ecc_settings.svh"

module eccCorrector (
  input  ecc_code_pkg::codeT code_i,
  output ecc_code_pkg::codeT code_o,
  output logic               errCorrectable_o,
  output logic               errUncorrectable_o
);

  import ecc_code_pkg::*;

  // position of a single faulty bit, zero when the Hamming part is clean
  syndromeT syndrome;
  // odd parity over the whole word means an odd number of flipped bits
  logic     parityOdd;
  // a syndrome past the last position cannot come from a single fault
  logic     inRange;

  assign syndrome  = calcSyndrome(code_i);
  assign parityOdd = ^code_i;
  assign inRange   = int'(syndrome) < CODE_WIDTH;

  always_comb begin
    code_o             = code_i;
    errCorrectable_o   = 1'b0;
    errUncorrectable_o = 1'b0;

    if (parityOdd) begin
      if (inRange) begin
        // one bit flipped, the syndrome names it
        // a zero syndrome names bit 0, the overall parity bit itself
        code_o[syndrome]  = ~code_i[syndrome];
        errCorrectable_o  = 1'b1;
      end else begin
        // odd count but no valid position, three or more faults
        errUncorrectable_o = 1'b1;
      end
    end else if (syndrome != '0) begin
      // even count with a nonzero syndrome is a double fault
      // the word goes out as stored since no single fix exists
      errUncorrectable_o = 1'b1;
    end
  end

  // the two flags are exclusive by construction of the branches above

endmodule

// File: design/eccEncoder.sv
// ##################################################
// combinational SECDED encoder
// turns a data word into the stored codeword
// ##################################################

`timescale 1ns/1ps

`include "ecc_settings.svh"

module eccEncoder (
  input  ecc_code_pkg::dataT data_i,
  output ecc_code_pkg::codeT code_o
);

  import ecc_code_pkg::*;

  // data scattered into place with all parity positions still zero
  codeT scattered;
  // with zero parity positions the syndrome is exactly the check bits
  syndromeT checkBits;
  // codeword before the overall parity bit is set
  codeT withChecks;

  assign scattered = insertData(data_i);
  assign checkBits = calcSyndrome(scattered);

  // each power-of-two position takes the check bit named by its single set bit
  always_comb begin
    withChecks = scattered;
    for (int pos = 1; pos < CODE_WIDTH; pos++) begin
      if (isParityPos(pos)) begin
        withChecks[pos] = |(checkBits & syndromeT'(pos));
      end
    end
  end

  // bit 0 makes the parity of the whole word even
  // this is what lets the corrector tell single from double faults
  always_comb begin
    code_o    = withChecks;
    code_o[0] = ^withChecks[CODE_WIDTH-1:1];
  end

  // the all-zero data word maps to the all-zero codeword
  // so the reset value of the register is a valid word

endmodule

// File: design/ecc_status_pkg.sv
// ##################################################
// types of the configuration and status block
// address map and event counter width
// ##################################################

`include "ecc_settings.svh"

package ecc_status_pkg;

  // configuration bus data is one 32-bit word
  typedef logic [31:0] cfgDataT;

  // saturating error event counter
  typedef logic [`COUNT_WIDTH-1:0] countT;

  // address map of the configuration block
  // CTRL bit 0 is the self-correct enable
  // INJECT takes a one-shot fault mask and reads back zero
  // the two counters are cleared by any write
  typedef enum logic [`CFG_ADDR_WIDTH-1:0] {
    CTRL         = 2'd0,
    INJECT       = 2'd1,
    CORR_COUNT   = 2'd2,
    UNCORR_COUNT = 2'd3
  } cfgAddrT;

  // largest counter value, the counters stop here
  localparam countT COUNT_MAX = '1;

endpackage

// File: design/ecc_code_pkg.sv
// ##################################################
// SECDED code types and helpers
// shared by the encoder, the corrector and the top
// ##################################################

`include "ecc_settings.svh"

package ecc_code_pkg;

  // positions 1 to 38 hold data and parity interleaved, bit 0 is overall parity
  localparam int CODE_WIDTH = `DATA_WIDTH + `PARITY_WIDTH;
  localparam int SYN_WIDTH  = `PARITY_WIDTH - 1;

  typedef logic [`DATA_WIDTH-1:0] dataT;
  typedef logic [CODE_WIDTH-1:0]  codeT;
  typedef logic [SYN_WIDTH-1:0]   syndromeT;

  // Hamming parity bits sit at the power-of-two positions
  function automatic logic isParityPos(input int pos);
    return (pos != 0) && ((pos & (pos - 1)) == 0);
  endfunction

  // xor of every position whose index has syndrome bit b set
  // a parity position is covered only by its own check bit
  function automatic syndromeT calcSyndrome(input codeT code);
    syndromeT syn;
    syn = '0;
    for (int pos = 1; pos < CODE_WIDTH; pos++) begin
      for (int b = 0; b < SYN_WIDTH; b++) begin
        if (pos[b]) begin
          syn[b] = syn[b] ^ code[pos];
        end
      end
    end
    return syn;
  endfunction

  // places the data bits in ascending order into the non-parity positions
  function automatic codeT insertData(input dataT data);
    codeT code;
    int   idx;
    code = '0;
    idx  = 0;
    for (int pos = 1; pos < CODE_WIDTH; pos++) begin
      if (!isParityPos(pos)) begin
        code[pos] = data[idx];
        idx++;
      end
    end
    return code;
  endfunction

  // reverse of insertData, parity and overall bits are dropped
  function automatic dataT extractData(input codeT code);
    dataT data;
    int   idx;
    data = '0;
    idx  = 0;
    for (int pos = 1; pos < CODE_WIDTH; pos++) begin
      if (!isParityPos(pos)) begin
        data[idx] = code[pos];
        idx++;
      end
    end
    return data;
  endfunction

endpackage

// File: design/ecc_settings.svh
// ##################################################
// width settings shared by the ECC register design
// include this wherever a width is needed
// ##################################################

`ifndef ECC_SETTINGS_SVH
`define ECC_SETTINGS_SVH

// width of the user data word held in the register
`define DATA_WIDTH 32

// six Hamming bits plus the overall parity bit
`define PARITY_WIDTH 7

// the configuration block decodes four addresses
`define CFG_ADDR_WIDTH 2

// error event counters saturate at their maximum
`define COUNT_WIDTH 16

`endif
